// ==== rtl/load_op_pkg.sv ====
package load_op_pkg;

    // --------------------
    // data path widths
    // --------------------

    // width of an integer register and of one cache data word
    localparam int unsigned XLEN = 64;

    // byte position of a load inside one data word
    // the cache always returns the whole aligned word
    localparam int unsigned OFFSET_BITS = 3;

    // --------------------
    // load operations
    // --------------------

    // the U variants fill the upper bits with zeros
    // LW, LH and LB copy the sign bit of the loaded field instead
    // LD moves the full data word and needs no extension at all
    typedef enum logic [2:0] {
        LD  = 3'd0,
        LW  = 3'd1,
        LWU = 3'd2,
        LH  = 3'd3,
        LHU = 3'd4,
        LB  = 3'd5,
        LBU = 3'd6
    } load_op_e;

endpackage

// ==== rtl/dcache_pkg.sv ====
package dcache_pkg;

    // --------------------
    // request geometry
    // --------------------

    // the index goes out with the request, the tag one cycle after the grant
    // together they cover the 32-bit load address
    localparam int unsigned INDEX_W = 12;
    localparam int unsigned TAG_W = 20;

    // one enable per byte of the 64-bit data word
    localparam int unsigned BE_W = 8;

    // --------------------
    // load buffer sizing
    // --------------------

    // scoreboard id that comes back with the result
    localparam int unsigned TRANS_ID_W = 3;

    // number of loads that may wait for their response at one time
    localparam int unsigned LDBUF_ENTRIES = 4;

    // the cache echoes this id, and it is also the buffer slot of the load
    localparam int unsigned REQ_ID_W = 2;

endpackage

// ==== rtl/ldbuf_wr_if.sv ====
interface ldbuf_wr_if;
    import load_op_pkg::*;
    import dcache_pkg::*;

    // write strobe, high in the cycle the cache grants the request
    logic                   we;
    // payload kept until the response comes back
    logic [TRANS_ID_W-1:0]  trans_id;
    logic [OFFSET_BITS-1:0] offset;
    load_op_e               op;

    // no new request may start while every slot is taken
    logic                   full;
    // slot the next load goes to, also used as the cache request id
    logic [REQ_ID_W-1:0]    free_idx;

    // request side
    modport fsm (
        output we, trans_id, offset, op,
        input  full, free_idx
    );

    // buffer side
    modport ldbuf (
        input  we, trans_id, offset, op,
        output full, free_idx
    );

endinterface

// ==== rtl/load_req_fsm.sv ====
module load_req_fsm (
    input  logic                                             clk_i,
    input  logic                                             rst_ni,
    input  logic                                             flush_i,
    input  logic                                             valid_i,
    input  logic [dcache_pkg::TRANS_ID_W-1:0]                trans_id_i,
    input  logic [dcache_pkg::INDEX_W+dcache_pkg::TAG_W-1:0] vaddr_i,
    input  load_op_pkg::load_op_e                            operation_i,
    input  logic                                             dcache_gnt_i,
    output logic                                             pop_ld_o,
    output logic                                             dcache_req_o,
    output logic [dcache_pkg::INDEX_W-1:0]                   dcache_index_o,
    output logic [dcache_pkg::TAG_W-1:0]                     dcache_tag_o,
    output logic                                             dcache_tag_valid_o,
    output logic                                             dcache_kill_o,
    output logic [dcache_pkg::BE_W-1:0]                      dcache_be_o,
    output logic [1:0]                                       dcache_size_o,
    output logic [dcache_pkg::REQ_ID_W-1:0]                  dcache_id_o,
    output logic                                             kill_o,
    ldbuf_wr_if.fsm                                          wr
);
    import load_op_pkg::*;
    import dcache_pkg::*;

    enum logic [1:0] {IDLE, WAIT_GNT, SEND_TAG, KILL_REQ} state_d, state_q;

    logic [OFFSET_BITS-1:0] offset;
    logic [TAG_W-1:0]       tag_q;
    logic                   accept;
    logic                   offset_ok;

    // the index is sent with the request, the upper bits wait for the tag cycle
    assign offset         = vaddr_i[OFFSET_BITS-1:0];
    assign dcache_index_o = vaddr_i[INDEX_W-1:0];
    assign dcache_tag_o   = tag_q;

    // the free buffer slot doubles as the id the cache hands back
    assign dcache_id_o = wr.free_idx;
    assign kill_o      = dcache_kill_o;

    // the load enters the buffer in the same cycle its request is granted
    assign wr.we       = dcache_req_o & dcache_gnt_i;
    assign wr.trans_id = trans_id_i;
    assign wr.offset   = offset;
    assign wr.op       = operation_i;

    // a new load needs a free slot, otherwise valid_i simply waits
    assign accept = valid_i & ~wr.full;

    // --------------------
    // byte enables
    // --------------------

    // enables start at the byte offset, size is log2 of the byte count
    always_comb begin
        case (operation_i)
            LW, LWU: begin
                dcache_be_o   = BE_W'(4'hf) << offset;
                dcache_size_o = 2'b10;
            end
            LH, LHU: begin
                dcache_be_o   = BE_W'(2'h3) << offset;
                dcache_size_o = 2'b01;
            end
            LB, LBU: begin
                dcache_be_o   = BE_W'(1'b1) << offset;
                dcache_size_o = 2'b00;
            end
            default: begin
                dcache_be_o   = '1;
                dcache_size_o = 2'b11;
            end
        endcase
    end

    // natural alignment of the offset for the access size
    always_comb begin
        case (operation_i)
            LW, LWU: offset_ok = (offset[1:0] == 2'b00);
            LH, LHU: offset_ok = ~offset[0];
            LB, LBU: offset_ok = 1'b1;
            default: offset_ok = (offset == '0);
        endcase
    end

    // --------------------
    // request control
    // --------------------

    always_comb begin
        state_d            = state_q;
        dcache_req_o       = 1'b0;
        dcache_tag_valid_o = 1'b0;
        dcache_kill_o      = 1'b0;
        pop_ld_o           = 1'b0;

        case (state_q)
            // the tag of the previous load goes out while the next index is sent
            IDLE, SEND_TAG: begin
                dcache_tag_valid_o = (state_q == SEND_TAG);
                state_d            = IDLE;
                if (accept) begin
                    dcache_req_o = 1'b1;
                    if (dcache_gnt_i) begin
                        pop_ld_o = 1'b1;
                        state_d  = SEND_TAG;
                    end else begin
                        state_d = WAIT_GNT;
                    end
                end
            end
            // hold the request as it is until the cache takes it
            WAIT_GNT: begin
                dcache_req_o = 1'b1;
                if (dcache_gnt_i) begin
                    pop_ld_o = 1'b1;
                    state_d  = SEND_TAG;
                end
            end
            // a tag cycle with kill tells the cache to drop the request
            KILL_REQ: begin
                dcache_kill_o      = 1'b1;
                dcache_tag_valid_o = 1'b1;
                state_d            = IDLE;
            end
            default: state_d = IDLE;
        endcase

        // whatever was going on, the cycle after a flush kills it
        if (flush_i) begin
            state_d = KILL_REQ;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // tag captured at the grant, valid only in the following cycle
    always_ff @(posedge clk_i) begin
        if (dcache_req_o && dcache_gnt_i) begin
            tag_q <= vaddr_i[INDEX_W+TAG_W-1:INDEX_W];
        end
    end

    // the cache may take its time, but the request must not move meanwhile
    a_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        dcache_req_o && !dcache_gnt_i && !flush_i
        |=> dcache_req_o && $stable(dcache_index_o) && $stable(dcache_id_o));

    // the issue stage only hands over naturally aligned loads
    a_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
        dcache_req_o |-> offset_ok);

endmodule

// ==== rtl/load_buffer.sv ====
module load_buffer (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic                                flush_i,
    input  logic                                kill_i,
    input  logic                                dcache_rvalid_i,
    input  logic [dcache_pkg::REQ_ID_W-1:0]     dcache_rid_i,
    ldbuf_wr_if.ldbuf                           wr,
    output logic                                valid_o,
    output logic [dcache_pkg::TRANS_ID_W-1:0]   trans_id_o,
    output load_op_pkg::load_op_e               rd_op_o,
    output logic [load_op_pkg::OFFSET_BITS-1:0] rd_offset_o
);
    import load_op_pkg::*;
    import dcache_pkg::*;

    logic [LDBUF_ENTRIES-1:0] valid_q, valid_d;
    logic [LDBUF_ENTRIES-1:0] flushed_q, flushed_d;
    logic [TRANS_ID_W-1:0]    trans_id_q [LDBUF_ENTRIES];
    logic [OFFSET_BITS-1:0]   offset_q [LDBUF_ENTRIES];
    load_op_e                 op_q [LDBUF_ENTRIES];
    logic [REQ_ID_W-1:0]      last_q;
    logic [REQ_ID_W-1:0]      slot_q;
    logic [REQ_ID_W-1:0]      lowest_free;

    // --------------------
    // slot allocation
    // --------------------

    // priority search, the lowest free entry wins
    always_comb begin
        lowest_free = '0;
        for (int i = LDBUF_ENTRIES - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                lowest_free = REQ_ID_W'(i);
            end
        end
    end

    // keep the chosen slot until it is taken, so a response that frees a
    // lower entry does not change the id of a request waiting for its grant
    assign wr.free_idx = valid_q[slot_q] ? lowest_free : slot_q;
    assign wr.full     = &valid_q;

    always_comb begin
        valid_d   = valid_q;
        flushed_d = flushed_q;
        // a response frees its entry, a write in the same cycle goes elsewhere
        if (dcache_rvalid_i) begin
            valid_d[dcache_rid_i] = 1'b0;
        end
        if (wr.we) begin
            valid_d[wr.free_idx]   = 1'b1;
            flushed_d[wr.free_idx] = 1'b0;
        end
        // a load written during the flush belongs to the flushed ones as well
        if (flush_i) begin
            flushed_d = '1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q   <= '0;
            flushed_q <= '0;
            last_q    <= '0;
            slot_q    <= '0;
        end else begin
            valid_q   <= valid_d;
            flushed_q <= flushed_d;
            slot_q    <= wr.free_idx;
            if (wr.we) begin
                last_q <= wr.free_idx;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr.we) begin
            trans_id_q[wr.free_idx] <= wr.trans_id;
            offset_q[wr.free_idx]   <= wr.offset;
            op_q[wr.free_idx]       <= wr.op;
        end
    end

    // --------------------
    // response lookup
    // --------------------

    assign trans_id_o  = trans_id_q[dcache_rid_i];
    assign rd_op_o     = op_q[dcache_rid_i];
    assign rd_offset_o = offset_q[dcache_rid_i];

    // drop the result of a flushed load, and of the newest one while it is killed
    assign valid_o = dcache_rvalid_i & ~flushed_q[dcache_rid_i]
                   & ~(kill_i & (last_q == dcache_rid_i));

    // the cache only answers requests that are still outstanding
    a_rid_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        dcache_rvalid_i |-> valid_q[dcache_rid_i]);

endmodule

// ==== rtl/load_result_align.sv ====
module load_result_align (
    input  logic [load_op_pkg::XLEN-1:0]        dcache_rdata_i,
    input  load_op_pkg::load_op_e               op_i,
    input  logic [load_op_pkg::OFFSET_BITS-1:0] offset_i,
    output logic [load_op_pkg::XLEN-1:0]        result_o
);
    import load_op_pkg::*;

    logic [XLEN-1:0]        shifted;
    logic [XLEN/8-1:0]      byte_msb;
    logic [OFFSET_BITS-1:0] sign_byte;
    logic                   is_signed;
    logic                   sign_bit;

    // move the loaded field down to bit 0
    assign shifted = dcache_rdata_i >> {offset_i, 3'b000};

    // --------------------
    // sign selection
    // --------------------

    // top bit of every byte, taken straight from the unshifted data so the
    // sign select runs beside the shifter and not behind it
    for (genvar i = 0; i < XLEN / 8; i++) begin : gen_byte_msb
        assign byte_msb[i] = dcache_rdata_i[8*i+7];
    end

    // the sign sits in the highest byte of the field
    always_comb begin
        case (op_i)
            LW:      sign_byte = offset_i + OFFSET_BITS'(3);
            LH:      sign_byte = offset_i + OFFSET_BITS'(1);
            default: sign_byte = offset_i;
        endcase
    end

    // unsigned loads extend with zeros
    assign is_signed = op_i inside {LW, LH, LB};
    assign sign_bit  = is_signed & byte_msb[sign_byte];

    // --------------------
    // extension
    // --------------------

    always_comb begin
        case (op_i)
            LW, LWU: result_o = {{(XLEN - 32){sign_bit}}, shifted[31:0]};
            LH, LHU: result_o = {{(XLEN - 16){sign_bit}}, shifted[15:0]};
            LB, LBU: result_o = {{(XLEN - 8){sign_bit}}, shifted[7:0]};
            default: result_o = shifted;
        endcase
    end

endmodule

// ==== rtl/load_unit.sv ====
module load_unit (
    input  logic                                             clk_i,
    input  logic                                             rst_ni,
    input  logic                                             flush_i,
    // load from the issue stage
    input  logic                                             valid_i,
    input  logic [dcache_pkg::TRANS_ID_W-1:0]                trans_id_i,
    input  logic [dcache_pkg::INDEX_W+dcache_pkg::TAG_W-1:0] vaddr_i,
    input  load_op_pkg::load_op_e                            operation_i,
    output logic                                             pop_ld_o,
    // data cache request
    output logic                                             dcache_req_o,
    input  logic                                             dcache_gnt_i,
    output logic [dcache_pkg::INDEX_W-1:0]                   dcache_index_o,
    output logic [dcache_pkg::TAG_W-1:0]                     dcache_tag_o,
    output logic                                             dcache_tag_valid_o,
    output logic                                             dcache_kill_o,
    output logic [dcache_pkg::BE_W-1:0]                      dcache_be_o,
    output logic [1:0]                                       dcache_size_o,
    output logic [dcache_pkg::REQ_ID_W-1:0]                  dcache_id_o,
    // data cache response
    input  logic                                             dcache_rvalid_i,
    input  logic [dcache_pkg::REQ_ID_W-1:0]                  dcache_rid_i,
    input  logic [load_op_pkg::XLEN-1:0]                     dcache_rdata_i,
    // result to writeback
    output logic                                             valid_o,
    output logic [dcache_pkg::TRANS_ID_W-1:0]                trans_id_o,
    output logic [load_op_pkg::XLEN-1:0]                     result_o
);

    // entry write path from the controller into the buffer
    ldbuf_wr_if wr_if ();

    logic                                kill;
    load_op_pkg::load_op_e               rd_op;
    logic [load_op_pkg::OFFSET_BITS-1:0] rd_offset;

    load_req_fsm i_req_fsm (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .flush_i            (flush_i),
        .valid_i            (valid_i),
        .trans_id_i         (trans_id_i),
        .vaddr_i            (vaddr_i),
        .operation_i        (operation_i),
        .dcache_gnt_i       (dcache_gnt_i),
        .pop_ld_o           (pop_ld_o),
        .dcache_req_o       (dcache_req_o),
        .dcache_index_o     (dcache_index_o),
        .dcache_tag_o       (dcache_tag_o),
        .dcache_tag_valid_o (dcache_tag_valid_o),
        .dcache_kill_o      (dcache_kill_o),
        .dcache_be_o        (dcache_be_o),
        .dcache_size_o      (dcache_size_o),
        .dcache_id_o        (dcache_id_o),
        .kill_o             (kill),
        .wr                 (wr_if.fsm)
    );

    load_buffer i_load_buffer (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .flush_i         (flush_i),
        .kill_i          (kill),
        .dcache_rvalid_i (dcache_rvalid_i),
        .dcache_rid_i    (dcache_rid_i),
        .wr              (wr_if.ldbuf),
        .valid_o         (valid_o),
        .trans_id_o      (trans_id_o),
        .rd_op_o         (rd_op),
        .rd_offset_o     (rd_offset)
    );

    // the result is aligned in the response cycle with no register
    load_result_align i_result_align (
        .dcache_rdata_i (dcache_rdata_i),
        .op_i           (rd_op),
        .offset_i       (rd_offset),
        .result_o       (result_o)
    );

endmodule

// ==== verif/tb_clk_gen.sv ====
module tb_clk_gen (
    output logic clk_o,
    output logic rst_no
);

    // free running clock with a period of 100
    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

    // reset covers the first two rising edges and is released on a falling edge
    initial begin
        rst_no = 1'b0;
        repeat (2) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule

// ==== verif/tb_load_unit.sv ====
module tb_load_unit;
    import load_op_pkg::*;
    import dcache_pkg::*;

    logic                     clk, rst_n;
    logic                     flush_i, valid_i, pop_ld_o;
    logic [TRANS_ID_W-1:0]    trans_id_i, trans_id_o;
    logic [31:0]              vaddr_i;
    load_op_e                 operation_i;
    logic                     dcache_req_o, dcache_gnt_i, dcache_tag_valid_o, dcache_kill_o;
    logic [INDEX_W-1:0]       dcache_index_o, held_index;
    logic [TAG_W-1:0]         dcache_tag_o, exp_tag;
    logic [BE_W-1:0]          dcache_be_o, exp_be;
    logic [1:0]               dcache_size_o, exp_size;
    logic [REQ_ID_W-1:0]      dcache_id_o, dcache_rid_i, pick;
    logic                     dcache_rvalid_i, valid_o, coin;
    logic [XLEN-1:0]          dcache_rdata_i, result_o, exp_result;
    // scoreboard of granted requests, indexed by the cache request id
    logic [LDBUF_ENTRIES-1:0] live, flushed;
    logic [TRANS_ID_W-1:0]    sb_trans [LDBUF_ENTRIES];
    logic [2:0]               sb_off [LDBUF_ENTRIES];
    load_op_e                 sb_op [LDBUF_ENTRIES];
    logic                     exp_valid, held, waiting, tag_due, flush_seen, hold_resp;
    logic [TRANS_ID_W-1:0]    exp_trans;
    logic [31:0]              stim_lfsr, cache_lfsr;
    int                       gnt_wait;
    int                       err_cnt = 0;
    int                       test_cnt = 0;

    tb_clk_gen clk_gen (.clk_o(clk), .rst_no(rst_n));

    load_unit DUT (.clk_i(clk), .rst_ni(rst_n), .*);

    // --------------------
    // helpers
    // --------------------

    // fibonacci LFSR with taps 32 22 2 1, stepped once per bit taken
    function automatic logic [63:0] take_bits(inout logic [31:0] state, input int n);
        logic [63:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb    = state[31] ^ state[21] ^ state[1] ^ state[0];
            state = {state[30:0], fb};
            bits  = {bits[62:0], fb};
        end
        return bits;
    endfunction

    // reference rule: field starts at byte off, then sign or zero extension
    function automatic logic [XLEN-1:0] load_ref(load_op_e op, logic [2:0] off,
                                                 logic [XLEN-1:0] data);
        logic [XLEN-1:0] field;
        field = data >> (8 * off);
        case (op)
            LW:      return XLEN'($signed(field[31:0]));
            LWU:     return XLEN'(field[31:0]);
            LH:      return XLEN'($signed(field[15:0]));
            LHU:     return XLEN'(field[15:0]);
            LB:      return XLEN'($signed(field[7:0]));
            LBU:     return XLEN'(field[7:0]);
            default: return field;
        endcase
    endfunction

    // natural alignment, low offset bits cleared by access size
    function automatic logic [2:0] align_offset(load_op_e op, logic [2:0] raw);
        case (op)
            LD:      return 3'b000;
            LW, LWU: return {raw[2], 2'b00};
            LH, LHU: return {raw[2:1], 1'b0};
            default: return raw;
        endcase
    endfunction

    // number of bytes that the operation reads
    function automatic int access_bytes(load_op_e op);
        case (op)
            LW, LWU: return 4;
            LH, LHU: return 2;
            LB, LBU: return 1;
            default: return 8;
        endcase
    endfunction

    // one enable for each byte from the offset up to the end of the field
    function automatic logic [BE_W-1:0] expect_be(load_op_e op, logic [2:0] off);
        logic [BE_W-1:0] be;
        be = '0;
        for (int b = 0; b < BE_W; b++) begin
            be[b] = (b >= int'(off)) && (b < int'(off) + access_bytes(op));
        end
        return be;
    endfunction

    // the size field is log2 of the byte count
    function automatic logic [1:0] expect_size(load_op_e op);
        logic [1:0] size;
        size = 2'd0;
        while ((1 << size) < access_bytes(op)) begin
            size++;
        end
        return size;
    endfunction

    function automatic load_op_e random_op();
        logic [2:0] raw;
        raw = 3'(take_bits(stim_lfsr, 3));
        return (raw == 3'd7) ? LD : load_op_e'(raw);
    endfunction

    task automatic mismatch(string name, logic [XLEN-1:0] got, logic [XLEN-1:0] exp);
        err_cnt++;
        $display("Mismatch at %0t: %s is %0h, expected %0h", $time, name, got, exp);
    endtask

    task automatic failure(string what);
        err_cnt++;
        $display("Error at %0t: %s", $time, what);
    endtask

    task automatic abort(string what);
        $display("Timeout at %0t: %s", $time, what);
        $display("Errors found");
        $finish;
    endtask

    task automatic finish_test(string name);
        test_cnt++;
        $display("test %0d (%s) finished, %0d errors so far", test_cnt, name, err_cnt);
    endtask

    task automatic present_load(input load_op_e op);
        logic [31:0] addr;
        addr      = 32'(take_bits(stim_lfsr, 32));
        addr[2:0] = align_offset(op, addr[2:0]);
        @(negedge clk);
        valid_i     = 1'b1;
        trans_id_i  = trans_id_i + 1'b1;
        vaddr_i     = addr;
        operation_i = op;
    endtask

    task automatic wait_pop();
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > 50) abort("load never popped");
        end while (!pop_ld_o);
    endtask

    task automatic issue_load(input load_op_e op);
        present_load(op);
        wait_pop();
    endtask

    // stop presenting and wait until every granted load has its response
    task automatic drain();
        int waited;
        @(negedge clk);
        valid_i = 1'b0;
        waited  = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > 200) abort("outstanding loads never answered");
        end while (live != '0);
    endtask

    // --------------------
    // monitor
    // --------------------

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            live       <= '0;
            flushed    <= '0;
            held       <= 1'b0;
            waiting    <= 1'b0;
            tag_due    <= 1'b0;
            flush_seen <= 1'b0;
        end else begin
            held       <= dcache_req_o && !dcache_gnt_i && !flush_i;
            waiting    <= dcache_req_o && !dcache_gnt_i;
            tag_due    <= dcache_req_o && dcache_gnt_i;
            held_index <= dcache_index_o;
            exp_tag    <= vaddr_i[31:12];
            flush_seen <= flush_i;
            if (dcache_rvalid_i) live[dcache_rid_i] <= 1'b0;
            if (dcache_req_o && dcache_gnt_i) begin
                live[dcache_id_o]     <= 1'b1;
                flushed[dcache_id_o]  <= 1'b0;
                sb_trans[dcache_id_o] <= trans_id_i;
                sb_op[dcache_id_o]    <= operation_i;
                sb_off[dcache_id_o]   <= vaddr_i[2:0];
            end
            // a load granted in the flush cycle is flushed as well
            if (flush_i) flushed <= '1;
        end
    end

    // --------------------
    // cache model
    // --------------------

    // grants after 0 to 3 waiting cycles, answers a random live id
    initial begin
        dcache_gnt_i    = 1'b0;
        dcache_rvalid_i = 1'b0;
        dcache_rid_i    = '0;
        dcache_rdata_i  = '0;
        exp_valid       = 1'b0;
        exp_trans       = '0;
        exp_result      = '0;
        cache_lfsr      = 32'hbfd3_ad8d;
        gnt_wait        = 0;
        forever begin
            @(negedge clk);
            if (tag_due) gnt_wait = int'(take_bits(cache_lfsr, 2));
            else if (waiting && gnt_wait > 0) gnt_wait--;
            dcache_gnt_i    = (gnt_wait == 0);
            dcache_rvalid_i = 1'b0;
            pick            = 2'(take_bits(cache_lfsr, 2));
            coin            = 1'(take_bits(cache_lfsr, 1));
            if (!hold_resp && live != '0 && coin) begin
                for (int i = 0; i < LDBUF_ENTRIES && !live[pick]; i++) pick = pick + 1'b1;
                dcache_rvalid_i = 1'b1;
                dcache_rid_i    = pick;
                dcache_rdata_i  = take_bits(cache_lfsr, 64);
                exp_valid       = !flushed[pick];
                exp_trans       = sb_trans[pick];
                exp_result      = load_ref(sb_op[pick], sb_off[pick], dcache_rdata_i);
            end
        end
    end

    // --------------------
    // checks
    // --------------------

    // enables and size expected for the load that is presented
    assign exp_be   = expect_be(operation_i, vaddr_i[2:0]);
    assign exp_size = expect_size(operation_i);

    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !(dcache_req_o
        || dcache_tag_valid_o || dcache_kill_o || pop_ld_o || valid_o))
        else failure("control outputs not low during reset");
    a_valid: assert property (@(posedge clk) disable iff (!rst_n)
        dcache_rvalid_i |-> valid_o == exp_valid)
        else mismatch("valid_o", 64'($sampled(valid_o)), 64'($sampled(exp_valid)));
    a_result: assert property (@(posedge clk) disable iff (!rst_n)
        dcache_rvalid_i && exp_valid |-> result_o == exp_result)
        else mismatch("result_o", $sampled(result_o), $sampled(exp_result));
    a_trans: assert property (@(posedge clk) disable iff (!rst_n)
        dcache_rvalid_i && exp_valid |-> trans_id_o == exp_trans)
        else mismatch("trans_id_o", 64'($sampled(trans_id_o)), 64'($sampled(exp_trans)));
    a_be: assert property (@(posedge clk) disable iff (!rst_n)
        dcache_req_o |-> dcache_be_o == exp_be)
        else mismatch("dcache_be_o", 64'($sampled(dcache_be_o)), 64'($sampled(exp_be)));
    a_size: assert property (@(posedge clk) disable iff (!rst_n)
        dcache_req_o |-> dcache_size_o == exp_size)
        else mismatch("dcache_size_o", 64'($sampled(dcache_size_o)), 64'($sampled(exp_size)));
    a_full_stall: assert property (@(posedge clk) disable iff (!rst_n)
        live == '1 |-> !dcache_req_o)
        else failure("request raised with four loads outstanding");
    a_req_held: assert property (@(posedge clk) disable iff (!rst_n) held |-> dcache_req_o)
        else failure("request dropped before its grant");
    a_index_held: assert property (@(posedge clk) disable iff (!rst_n)
        held |-> dcache_index_o == held_index)
        else mismatch("dcache_index_o", 64'($sampled(dcache_index_o)), 64'($sampled(held_index)));
    a_no_pop: assert property (@(posedge clk) disable iff (!rst_n)
        dcache_req_o && !dcache_gnt_i |-> !pop_ld_o)
        else failure("load popped without a grant");
    a_tag_valid: assert property (@(posedge clk) disable iff (!rst_n)
        tag_due |-> dcache_tag_valid_o)
        else failure("tag not valid in the cycle after the grant");
    a_tag: assert property (@(posedge clk) disable iff (!rst_n)
        tag_due |-> dcache_tag_o == exp_tag)
        else mismatch("dcache_tag_o", 64'($sampled(dcache_tag_o)), 64'($sampled(exp_tag)));
    a_kill: assert property (@(posedge clk) disable iff (!rst_n)
        flush_seen |-> dcache_kill_o && dcache_tag_valid_o)
        else failure("no kill with tag valid in the cycle after a flush");

    // --------------------
    // stimulus
    // --------------------

    initial begin
        int waited;
        flush_i     = 1'b0;
        valid_i     = 1'b0;
        trans_id_i  = '0;
        vaddr_i     = '0;
        operation_i = LD;
        hold_resp   = 1'b0;
        stim_lfsr   = 32'hbfd3_ad8d;
        waited      = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > 10) abort("reset never released");
        end while (!rst_n);
        finish_test("reset");

        for (int k = 0; k < 7; k++) issue_load(load_op_e'(k));
        drain();
        finish_test("every operation");

        // fill the buffer, then show a fifth load that has to wait
        hold_resp = 1'b1;
        repeat (4) issue_load(random_op());
        present_load(random_op());
        repeat (4) @(posedge clk);
        hold_resp = 1'b0;
        wait_pop();
        repeat (8) issue_load(random_op());
        drain();
        finish_test("four in flight");

        repeat (24) issue_load(random_op());
        drain();
        finish_test("withheld grants");

        // loads outstanding at the flush lose their results
        hold_resp = 1'b1;
        repeat (3) issue_load(random_op());
        @(negedge clk);
        valid_i = 1'b0;
        flush_i = 1'b1;
        @(negedge clk);
        flush_i = 1'b0;
        @(posedge clk);
        hold_resp = 1'b0;
        drain();
        repeat (3) issue_load(random_op());
        drain();
        finish_test("flush");

        $display("%0d tests run, %0d errors", test_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== src.f ====
rtl/load_op_pkg.sv
rtl/dcache_pkg.sv
rtl/ldbuf_wr_if.sv
rtl/load_req_fsm.sv
rtl/load_buffer.sv
rtl/load_result_align.sv
rtl/load_unit.sv
verif/tb_clk_gen.sv
verif/tb_load_unit.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_load_unit
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# a crash or the failure line in the log fails the run
run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	test $$status -eq 0 && ! grep -q "Errors found" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
